// ==== compile.f ====
hdl/pm_pkg.sv
hdl/pm_cycle_if.sv
hdl/univib.sv
hdl/group_counter.sv
hdl/step_counter.sv
hdl/cycle_ctl.sv
hdl/state_seq.sv
hdl/pm.sv
tb/pm_clock.sv
tb/pm_properties.sv
tb/pm_tb.sv

// ==== Bender.yml ====
package:
  name: pm

sources:
  - files:
      - hdl/pm_pkg.sv
      - hdl/pm_cycle_if.sv
      - hdl/univib.sv
      - hdl/group_counter.sv
      - hdl/step_counter.sv
      - hdl/cycle_ctl.sv
      - hdl/state_seq.sv
      - hdl/pm.sv
  - target: test
    files:
      - tb/pm_clock.sv
      - tb/pm_properties.sv
      - tb/pm_tb.sv

// ==== tb/pm_tb.sv ====
// ##########################################################
// random run of the P-M control unit against a clocked model
// inputs change on the falling edge, results checked there too
// ##########################################################
module pm_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import pm_pkg::*;

	localparam int TEST_INSTR = 2 + 20 + 12 + 4;
	localparam int WORST_CLOCKS = KC_TICKS + PC_TICKS + 2 + 4 + 16;

	logic clk, rst, start, stop, hlt, cycle, irq;
	ir_t ir;
	logic run, wait_ind, kc, pc, fetch, irq_ack;
	p_state_t state;
	lg_t lg;
	lk_t lk;
	int seed, errors, checks;

	pm_clock i_clk (.clk(clk), .rst(rst));

	pm i_dut (
		.__clk(clk), .rst(rst), .start(start), .stop(stop), .hlt(hlt),
		.cycle(cycle), .irq(irq), .ir(ir), .run(run), .wait_ind(wait_ind),
		.state(state), .kc(kc), .pc(pc), .fetch(fetch), .irq_ack(irq_ack),
		.lg(lg), .lk(lk)
	);

	// reference model registers
	logic m_start, m_wait, m_cycle, m_kc_d, m_pc_d, m_fq, m_iq, m_iend, m_pre, m_bm;
	int m_kcn, m_pcn, m_pcc;
	p_state_t m_st;
	lg_t m_lg;
	lk_t m_lk;
	logic m_run, m_kc, m_pc, m_req, m_irq, m_first, m_fetch, m_ack, m_ekc, m_idle, m_trig;
	logic m_pc_last;

	assign m_run = m_start & ~m_wait;
	assign m_kc = (m_kcn != 0);
	assign m_pc = (m_pcn != 0);
	assign m_req = m_run | m_cycle;
	assign m_irq = irq & (m_start | m_cycle);
	assign m_first = m_pc & ~m_pc_d;
	assign m_fetch = m_fq | (m_first & m_req & ~m_irq);
	assign m_ack = m_iq | (m_first & m_irq);
	assign m_ekc = ((m_st == P5) && (m_lk == 0)) | m_iend;
	assign m_idle = (m_st == P0) & ~(m_kc | m_pc | m_fetch | m_ack);
	assign m_trig = m_ekc | (m_idle & ~m_kc_d & (m_req | m_irq));
	assign m_pc_last = m_pc && (m_pcc == PC_TICKS - 1);

	always @(posedge clk) begin
		if (rst) begin
			{m_start, m_wait, m_cycle, m_kc_d, m_pc_d, m_fq, m_iq, m_iend} <= '0;
			{m_pre, m_bm} <= '0;
			m_kcn <= 0;
			m_pcn <= 0;
			m_pcc <= 0;
			m_st <= P0;
			m_lg <= '0;
			m_lk <= '0;
		end else begin
			m_kcn <= (m_kcn == 0) ? (m_trig ? KC_TICKS : 0) : m_kcn - 1;
			// PC starts once KC has gone low
			m_pcn <= (m_pcn == 0) ? ((m_kc_d && !m_kc) ? PC_TICKS : 0) : m_pcn - 1;
			m_kc_d <= m_kc;
			m_pc_d <= m_pc;
			m_pcc <= m_pc ? m_pcc + 1 : 0;
			m_start <= stop ? 1'b0 : (start ? 1'b1 : m_start);
			if (start || (m_first && m_irq))
				m_wait <= 1'b0;
			else if (m_kc && !m_kc_d && hlt)
				m_wait <= 1'b1;
			m_cycle <= cycle ? 1'b1 : (m_first ? 1'b0 : m_cycle);
			m_fq <= (m_trig && !m_kc) ? 1'b0 : m_fetch;
			m_iq <= (m_trig && !m_kc) ? 1'b0 : m_ack;
			m_iend <= m_pc_last && m_ack && (m_st == P0);
			case (m_st)
				P0: if (m_pc_last && m_fetch) m_st <= P1;
				P1: begin
					m_pre <= ir.pre_mod;
					m_bm <= ir.b_mod;
					m_lg <= ir.first_reg;
					m_lk <= ir.steps;
					m_st <= ir.two_word ? P2 : ir.pre_mod ? P3 : ir.b_mod ? P4 : P5;
				end
				P2: m_st <= m_pre ? P3 : m_bm ? P4 : P5;
				P3: m_st <= m_bm ? P4 : P5;
				P4: m_st <= P5;
				default: begin
					m_lg <= m_lg + 1'b1;
					if (m_lk != 0)
						m_lk <= m_lk - 1'b1;
					else
						m_st <= P0;
				end
			endcase
		end
	end

	task automatic check_state(p_state_t got, p_state_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: state %s, expected %s", $time, got.name(), exp.name());
		end
	endtask

	task automatic check_lg(lg_t got, lg_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: lg %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_lk(lk_t got, lk_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: lk %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_bit(string what, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// compare on the falling edge, then drive new inputs
	task automatic tick();
		@(negedge clk);
		if (!rst) begin
			check_state(state, m_st);
			check_lg(lg, m_lg);
			check_lk(lk, m_lk);
			check_bit("run", run, m_run);
			check_bit("wait_ind", wait_ind, m_wait);
			check_bit("kc", kc, m_kc);
			check_bit("pc", pc, m_pc);
			check_bit("fetch", fetch, m_fetch);
			check_bit("irq_ack", irq_ack, m_ack);
		end
		start = 1'b0;
		stop = 1'b0;
		cycle = 1'b0;
		ir = ir_t'($random(seed));
	endtask

	task automatic wait_state(p_state_t s, int limit);
		int n;
		n = 0;
		while (state !== s && n < limit) begin
			tick();
			n++;
		end
		if (state !== s) begin
			errors++;
			$display("timeout: the sequencer never reached %s", s.name());
		end
	endtask

	// sel 0 wait_ind, 1 irq_ack, 2 fetch
	task automatic wait_high(int sel, int limit);
		int n;
		logic [2:0] v;
		n = 0;
		v = {fetch, irq_ack, wait_ind};
		while (v[sel] !== 1'b1 && n < limit) begin
			tick();
			n++;
			v = {fetch, irq_ack, wait_ind};
		end
		if (v[sel] !== 1'b1) begin
			errors++;
			$display("timeout: %s never went high",
				(sel == 0) ? "wait_ind" : (sel == 1) ? "irq_ack" : "fetch");
		end
	endtask

	task automatic report(int n, string name, int err_start);
		$display("test %0d %s finished with %0d errors", n, name, errors - err_start);
	endtask

	initial begin
		#(TEST_INSTR * WORST_CLOCKS * 2 * 40);
		$display("watchdog expired before the tests finished");
		$display("Regression failed");
		$finish;
	end

	initial begin
		int e;
		seed = 27074;
		errors = 0;
		checks = 0;
		{start, stop, hlt, cycle, irq} = '0;
		ir = '0;
		@(negedge rst);

		e = errors;
		repeat (30) begin
			tick();
			check_bit("kc while quiet", kc, 1'b0);
		end
		report(1, "reset", e);

		e = errors;
		start = 1'b1;
		repeat (20) begin
			wait_state(P1, 80);
			wait_state(P0, 40);
		end
		report(2, "instruction walk", e);

		e = errors;
		hlt = 1'b1;
		wait_high(0, 80);
		repeat (40) begin
			tick();
			check_bit("fetch in wait", fetch, 1'b0);
		end
		irq = 1'b1;
		wait_high(1, 80);
		// hold irq through the decision clock
		tick();
		irq = 1'b0;
		hlt = 1'b0;
		wait_high(2, 80);
		check_bit("run after irq", run, 1'b1);
		tick();
		stop = 1'b1;
		wait_state(P1, 80);
		wait_state(P0, 40);
		repeat (20) begin
			tick();
			check_bit("fetch after stop", fetch, 1'b0);
		end
		report(3, "halt, interrupt, stop", e);

		e = errors;
		cycle = 1'b1;
		wait_state(P1, 80);
		wait_state(P0, 40);
		// skip the KC that ends the instruction
		repeat (KC_TICKS) tick();
		repeat (20) begin
			tick();
			check_bit("kc after single cycle", kc, 1'b0);
			check_bit("fetch after single cycle", fetch, 1'b0);
		end
		report(4, "single cycle", e);

		errors += i_dut.i_state_seq.i_props.fail_count;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== tb/pm_properties.sv ====
// ##########################################################
// assertions on the main loop and the one-shots
// ##########################################################
module pm_properties (
	input logic __clk,
	input logic rst,
	input pm_pkg::p_state_t state,
	input logic ekc,
	input logic kc,
	input logic pc
);
	timeunit 1ns;
	timeprecision 1ps;

	// failed assertions so far
	int fail_count = 0;

	a_state_onehot: assert property (@(posedge __clk) disable iff (rst) $onehot(state))
		else begin
			$error("state is not one-hot");
			fail_count++;
		end

	a_ekc_single: assert property (@(posedge __clk) disable iff (rst) ekc |=> !ekc)
		else begin
			$error("ekc wider than one clock");
			fail_count++;
		end

	// cycle end and cycle start never together
	a_kc_pc: assert property (@(posedge __clk) disable iff (rst) !(kc && pc))
		else begin
			$error("kc overlaps pc");
			fail_count++;
		end

endmodule

bind state_seq pm_properties i_props (
	.__clk(__clk),
	.rst(rst),
	.state(state),
	.ekc(cyc.ekc),
	.kc(cyc.kc),
	.pc(cyc.pc)
);

// ==== tb/pm_clock.sv ====
// ##########################################################
// testbench clock, 40 ns period, rst high for 3 cycles
// ##########################################################
module pm_clock (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== hdl/pm.sv ====
// ##########################################################
// P-M microinstruction control, cycle control and main loop
// start, stop and cycle are one-clock pulses, hlt and irq levels
// ##########################################################
module pm (
	input logic __clk,
	input logic rst,
	input logic start,
	input logic stop,
	input logic hlt,
	input logic cycle,
	input logic irq,
	input pm_pkg::ir_t ir,
	output logic run,
	output logic wait_ind,
	output pm_pkg::p_state_t state,
	output logic kc,
	output logic pc,
	output logic fetch,
	output logic irq_ack,
	output pm_pkg::lg_t lg,
	output pm_pkg::lk_t lk
);

	pm_cycle_if cyc ();

	// START / WAIT / CYCLE and the one-shots
	cycle_ctl i_cycle_ctl (
		.__clk(__clk),
		.rst(rst),
		.start(start),
		.stop(stop),
		.hlt(hlt),
		.cycle(cycle),
		.irq(irq),
		.run(run),
		.wait_ind(wait_ind),
		.cyc(cyc.ctl)
	);

	// P0..P5 with LG and LK
	state_seq i_state_seq (
		.__clk(__clk),
		.rst(rst),
		.ir(ir),
		.cyc(cyc.seq),
		.state(state),
		.lg(lg),
		.lk(lk)
	);

	// cycle framing visible at the top
	assign kc = cyc.kc;
	assign pc = cyc.pc;
	assign fetch = cyc.fetch;
	assign irq_ack = cyc.irq_ack;

endmodule

// ==== hdl/state_seq.sv ====
// ##########################################################
// main loop P0..P5, ir read in P1 only
// P5 runs steps + 1 clocks, ekc in its last clock
// ##########################################################
module state_seq (
	input logic __clk,
	input logic rst,
	input pm_pkg::ir_t ir,
	pm_cycle_if.seq cyc,
	output pm_pkg::p_state_t state,
	output pm_pkg::lg_t lg,
	output pm_pkg::lk_t lk
);
	import pm_pkg::*;

	p_state_t state_nx;
	logic [$clog2(PC_TICKS):0] pc_cnt;
	logic pc_last;
	logic irq_end;
	logic pre_mod_q;
	logic b_mod_q;
	logic lk_zero;
	logic in_p1;
	logic in_p5;

	assign in_p1 = (state == P1);
	assign in_p5 = (state == P5);

	// count PC clocks to spot the last one while PC is still high
	always_ff @(posedge __clk) begin
		if (rst || !cyc.pc) begin
			pc_cnt <= '0;
		end else begin
			pc_cnt <= pc_cnt + 1'b1;
		end
	end

	assign pc_last = cyc.pc && (pc_cnt == PC_TICKS - 1);

	group_counter i_lg (
		.__clk(__clk),
		.rst(rst),
		.load(in_p1),
		.inc(in_p5),
		.first(ir.first_reg),
		.lg(lg)
	);

	step_counter i_lk (
		.__clk(__clk),
		.rst(rst),
		.load(in_p1),
		.dec(in_p5),
		.count(ir.steps),
		.lk(lk),
		.zero(lk_zero)
	);

	// modifier bits for the states after P1
	always_ff @(posedge __clk) begin
		if (in_p1) begin
			pre_mod_q <= ir.pre_mod;
			b_mod_q <= ir.b_mod;
		end
	end

	always_comb begin
		state_nx = state;
		case (state)
			P0: begin
				if (pc_last && cyc.fetch) begin
					state_nx = P1;
				end
			end
			P1: begin
				if (ir.two_word) begin
					state_nx = P2;
				end else if (ir.pre_mod) begin
					state_nx = P3;
				end else if (ir.b_mod) begin
					state_nx = P4;
				end else begin
					state_nx = P5;
				end
			end
			P2: begin
				if (pre_mod_q) begin
					state_nx = P3;
				end else if (b_mod_q) begin
					state_nx = P4;
				end else begin
					state_nx = P5;
				end
			end
			P3: state_nx = b_mod_q ? P4 : P5;
			P4: state_nx = P5;
			P5: begin
				if (lk_zero) begin
					state_nx = P0;
				end
			end
			default: state_nx = P0;
		endcase
	end

	// interrupt receive ends right after PC
	always_ff @(posedge __clk) begin
		if (rst) begin
			state <= P0;
			irq_end <= 1'b0;
		end else begin
			state <= state_nx;
			irq_end <= pc_last && cyc.irq_ack && (state == P0);
		end
	end

	assign cyc.ekc = (in_p5 & lk_zero) | irq_end;
	assign cyc.idle = (state == P0) & ~(cyc.kc | cyc.pc | cyc.fetch | cyc.irq_ack);

endmodule

// ==== hdl/cycle_ctl.sv ====
// ##########################################################
// START, WAIT, CYCLE flip-flops and the KC / PC one-shots
// one idle clock sits between the fall of KC and PC
// an irq is taken with START or CYCLE set, even in WAIT
// ##########################################################
module cycle_ctl (
	input logic __clk,
	input logic rst,
	input logic start,
	input logic stop,
	input logic hlt,
	input logic cycle,
	input logic irq,
	output logic run,
	output logic wait_ind,
	pm_cycle_if.ctl cyc
);
	import pm_pkg::*;

	logic start_ff;
	logic wait_ff;
	logic cycle_ff;
	logic kc_d;
	logic pc_d;
	logic fetch_q;
	logic irq_q;
	logic req_run;
	logic req_irq;
	logic kc_trig;
	logic kc_rise;
	logic kc_fall;
	logic pc_first;
	logic fetch_now;
	logic irq_now;

	assign run = start_ff & ~wait_ff;
	assign wait_ind = wait_ff;

	// pending work for the next cycle
	assign req_run = run | cycle_ff;
	assign req_irq = irq & (start_ff | cycle_ff);

	// kc_d keeps the gap clock after KC from retriggering
	assign kc_trig = cyc.ekc | (cyc.idle & ~kc_d & (req_run | req_irq));
	assign kc_rise = cyc.kc & ~kc_d;
	assign kc_fall = kc_d & ~cyc.kc;
	assign pc_first = cyc.pc & ~pc_d;

	univib #(
		.ticks(KC_TICKS)
	) i_kc (
		.__clk(__clk),
		.rst(rst),
		.trig(kc_trig),
		.q(cyc.kc)
	);

	// PC chained to the fall of KC
	univib #(
		.ticks(PC_TICKS)
	) i_pc (
		.__clk(__clk),
		.rst(rst),
		.trig(kc_fall),
		.q(cyc.pc)
	);

	// interrupt wins over fetch
	assign irq_now = pc_first & req_irq;
	assign fetch_now = pc_first & req_run & ~req_irq;
	assign cyc.fetch = fetch_q | fetch_now;
	assign cyc.irq_ack = irq_q | irq_now;

	always_ff @(posedge __clk) begin
		if (rst) begin
			start_ff <= 1'b0;
			wait_ff <= 1'b0;
			cycle_ff <= 1'b0;
		end else begin
			if (stop) begin
				start_ff <= 1'b0;
			end else if (start) begin
				start_ff <= 1'b1;
			end
			// hlt only counts at the rise of KC
			if (start || irq_now) begin
				wait_ff <= 1'b0;
			end else if (kc_rise && hlt) begin
				wait_ff <= 1'b1;
			end
			if (cycle) begin
				cycle_ff <= 1'b1;
			end else if (pc_first) begin
				cycle_ff <= 1'b0;
			end
		end
	end

	// decision held until KC starts again
	always_ff @(posedge __clk) begin
		if (rst) begin
			kc_d <= 1'b0;
			pc_d <= 1'b0;
			fetch_q <= 1'b0;
			irq_q <= 1'b0;
		end else begin
			kc_d <= cyc.kc;
			pc_d <= cyc.pc;
			if (kc_trig && !cyc.kc) begin
				fetch_q <= 1'b0;
				irq_q <= 1'b0;
			end else begin
				fetch_q <= fetch_q | fetch_now;
				irq_q <= irq_q | irq_now;
			end
		end
	end

endmodule

// ==== hdl/step_counter.sv ====
// ##########################################################
// step counter LK, loadable, counts down and holds at zero
// ##########################################################
module step_counter (
	input logic __clk,
	input logic rst,
	input logic load,
	input logic dec,
	input pm_pkg::lk_t count,
	output pm_pkg::lk_t lk,
	output logic zero
);

	assign zero = (lk == '0);

	// dec at zero is a no-op
	always_ff @(posedge __clk) begin
		if (rst) begin
			lk <= '0;
		end else if (load) begin
			lk <= count;
		end else if (dec && !zero) begin
			lk <= lk - 1'b1;
		end
	end

endmodule

// ==== hdl/group_counter.sv ====
// ##########################################################
// register group counter LG, wraps from 7 to 0
// load has priority over inc
// ##########################################################
module group_counter (
	input logic __clk,
	input logic rst,
	input logic load,
	input logic inc,
	input pm_pkg::lg_t first,
	output pm_pkg::lg_t lg
);

	// preload with the first register of the group
	always_ff @(posedge __clk) begin
		if (rst) begin
			lg <= '0;
		end else if (load) begin
			lg <= first;
		end else if (inc) begin
			// natural modulo 8 wrap
			lg <= lg + 1'b1;
		end
	end

endmodule

// ==== hdl/univib.sv ====
// ##########################################################
// clocked one-shot, q high for ticks clocks after trig
// trig while q is high is ignored, ticks must be at least 1
// ##########################################################
module univib #(
	parameter int ticks = 1
) (
	input logic __clk,
	input logic rst,
	input logic trig,
	output logic q
);

	typedef logic [$clog2(ticks + 1) - 1:0] cnt_t;

	cnt_t cnt;

	// load on trigger only while idle
	always_ff @(posedge __clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (cnt == '0) begin
			if (trig) begin
				cnt <= cnt_t'(ticks);
			end
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	assign q = (cnt != '0);

endmodule

// ==== hdl/pm_cycle_if.sv ====
// ##########################################################
// cycle framing between run control and the sequencer
// ##########################################################
interface pm_cycle_if;

	logic kc;
	logic pc;
	logic fetch;
	logic irq_ack;
	logic ekc;
	logic idle;

	// run control side
	modport ctl (
		output kc,
		output pc,
		output fetch,
		output irq_ack,
		input ekc,
		input idle
	);

	modport seq (
		input kc,
		input pc,
		input fetch,
		input irq_ack,
		output ekc,
		output idle
	);

endinterface

// ==== hdl/pm_pkg.sv ====
// ##########################################################
// shared types of the P-M control unit
// state is one-hot, so any other value is illegal
// ##########################################################
package pm_pkg;

	// one-shot lengths in clocks
	localparam int KC_TICKS = 3;
	localparam int PC_TICKS = 2;

	typedef logic [2:0] lg_t;
	typedef logic [3:0] lk_t;

	// main loop states
	typedef enum logic [5:0] {
		P0 = 6'b000001,
		P1 = 6'b000010,
		P2 = 6'b000100,
		P3 = 6'b001000,
		P4 = 6'b010000,
		P5 = 6'b100000
	} p_state_t;

	// instruction word as seen by the control unit
	typedef struct packed {
		logic two_word;
		logic pre_mod;
		logic b_mod;
		// opcode and register fields, decoded elsewhere
		logic [3:0] rsv_hi;
		lg_t first_reg;
		logic [1:0] rsv_lo;
		lk_t steps;
	} ir_t;

endpackage
